/* hw/raster_apb_regs.sv */
`include "raster_defs.svh"

module raster_apb_regs (
    input  logic                      clock,
    input  logic                      reset,
    input  raster_pkg::apb_req_t      apb_req,
    output raster_pkg::apb_rsp_t      apb_rsp,
    output logic [`RASTER_ADDR_W-1:0] base_addr,
    output logic                      start,
    input  logic                      busy,
    input  logic                      done,
    input  logic                      consumed
);

    logic        access;
    logic        wr_en;
    logic        ctrl_go;
    logic [31:0] count;
    logic [31:0] rd_data;

    // no wait states, so every access phase completes
    assign access = apb_req.psel && apb_req.penable;
    assign wr_en  = access && apb_req.pwrite;

    // a run can only be launched from idle
    assign ctrl_go = wr_en && (apb_req.paddr == `RASTER_REG_CTRL) &&
                     apb_req.pwdata[0] && !busy;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            base_addr <= '0;
        end else if (wr_en && (apb_req.paddr == `RASTER_REG_BASE)) begin
            base_addr <= apb_req.pwdata[`RASTER_ADDR_W-1:0];
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            start <= 1'b0;
        end else begin
            start <= ctrl_go;
        end
    end

    // delivered triangles since the most recent start
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            count <= '0;
        end else if (start) begin
            count <= '0;
        end else if (consumed) begin
            count <= count + 32'd1;
        end
    end

    always_comb begin
        rd_data = '0;
        case (apb_req.paddr)
            `RASTER_REG_BASE: begin
                rd_data = {{(32 - `RASTER_ADDR_W){1'b0}}, base_addr};
            end
            `RASTER_REG_STATUS: begin
                rd_data = {30'd0, done, busy};
            end
            `RASTER_REG_COUNT: begin
                rd_data = count;
            end
            // CTRL reads back as zero since its only bit is a pulse
            default: begin
                rd_data = '0;
            end
        endcase
    end

    assign apb_rsp.prdata = (access && !apb_req.pwrite) ? rd_data : 32'd0;
    assign apb_rsp.pready = access;

endmodule

/* hw/raster_defs.svh */
`ifndef RASTER_DEFS_SVH
`define RASTER_DEFS_SVH

// memory byte-address width of the vertex buffer master port
`define RASTER_ADDR_W 26

// three vertices of five attributes each
`define RASTER_TRI_WORDS 15

// default number of whole triangles buffered toward the rasterizer
`define RASTER_FIFO_DEPTH 4

// APB register offsets
`define RASTER_REG_BASE   8'h00
`define RASTER_REG_CTRL   8'h04
`define RASTER_REG_STATUS 8'h08
`define RASTER_REG_COUNT  8'h0C

`endif

/* hw/raster_frontend_top.sv */
`include "raster_defs.svh"

module raster_frontend_top (
    input  logic                  clock,
    input  logic                  reset,
    input  raster_pkg::apb_req_t  apb_req,
    output raster_pkg::apb_rsp_t  apb_rsp,
    output raster_pkg::mem_req_t  mem_req,
    input  raster_pkg::mem_rsp_t  mem_rsp,
    output raster_pkg::triangle_t tri_out,
    output logic                  tri_valid,
    input  logic                  stall
);

    localparam int CNT_W = $clog2(`RASTER_FIFO_DEPTH + 1);

    logic [`RASTER_ADDR_W-1:0] base_addr;
    logic                      start;
    logic                      busy;
    logic                      done;
    logic                      push;
    logic                      pop;
    raster_pkg::triangle_t     push_tri;
    logic [CNT_W-1:0]          free_slots;

    // a triangle leaves whenever one is shown and the rasterizer is ready
    assign pop = tri_valid && !stall;

    raster_apb_regs u_regs (
        .clock     (clock),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .base_addr (base_addr),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .consumed  (pop)
    );

    vertex_fetch u_fetch (
        .clock      (clock),
        .reset      (reset),
        .base_addr  (base_addr),
        .start      (start),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .push       (push),
        .push_tri   (push_tri),
        .free_slots (free_slots),
        .consumed   (pop),
        .busy       (busy),
        .done       (done)
    );

    triangle_fifo #(
        .DEPTH (`RASTER_FIFO_DEPTH)
    ) u_fifo (
        .clock      (clock),
        .reset      (reset),
        .push       (push),
        .push_tri   (push_tri),
        .pop        (pop),
        .head       (tri_out),
        .not_empty  (tri_valid),
        .free_slots (free_slots)
    );

endmodule

/* hw/raster_pkg.sv */
`include "raster_defs.svh"

package raster_pkg;

    // word 0 is the first word read from memory and sits in the low bits
    typedef struct packed {
        logic [`RASTER_TRI_WORDS-1:0][31:0] word;
    } triangle_t;

    typedef struct packed {
        logic                      read;
        logic [`RASTER_ADDR_W-1:0] address;
    } mem_req_t;

    typedef struct packed {
        logic        waitrequest;
        logic        readdatavalid;
        logic [31:0] readdata;
    } mem_rsp_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        ISSUE_IDLE,
        ISSUE_HEADER,
        ISSUE_BURST,
        ISSUE_DONE
    } issue_state_e;

    typedef enum logic {
        RECV_HEADER,
        RECV_TRIANGLE
    } recv_state_e;

endpackage

/* hw/triangle_fifo.sv */
`include "raster_defs.svh"

module triangle_fifo #(
    parameter int DEPTH = `RASTER_FIFO_DEPTH
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         push,
    input  raster_pkg::triangle_t        push_tri,
    input  logic                         pop,
    output raster_pkg::triangle_t        head,
    output logic                         not_empty,
    output logic [$clog2(DEPTH+1)-1:0]   free_slots
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    raster_pkg::triangle_t slots [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;

    // pointers wrap explicitly so that DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clock) begin
        if (push) begin
            slots[wr_ptr] <= push_tri;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // show-ahead, the oldest triangle is always visible
    assign head       = slots[rd_ptr];
    assign not_empty  = (count != '0);
    assign free_slots = CNT_W'(DEPTH) - count;

endmodule

/* hw/vertex_fetch.sv */
`include "raster_defs.svh"

module vertex_fetch (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [`RASTER_ADDR_W-1:0]              base_addr,
    input  logic                                   start,
    output raster_pkg::mem_req_t                   mem_req,
    input  raster_pkg::mem_rsp_t                   mem_rsp,
    output logic                                   push,
    output raster_pkg::triangle_t                  push_tri,
    input  logic [$clog2(`RASTER_FIFO_DEPTH+1)-1:0] free_slots,
    input  logic                                   consumed,
    output logic                                   busy,
    output logic                                   done
);

    localparam int CNT_W = $clog2(`RASTER_FIFO_DEPTH + 1);
    localparam int IDX_W = $clog2(`RASTER_TRI_WORDS);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`RASTER_TRI_WORDS - 1);

    raster_pkg::issue_state_e issue_state;
    raster_pkg::recv_state_e  recv_state;

    logic [IDX_W-1:0] send_idx;
    logic [IDX_W-1:0] recv_idx;
    logic [31:0]      tri_count;
    logic [31:0]      issued_cnt;
    logic [31:0]      consumed_cnt;
    logic [CNT_W-1:0] reserved;

    logic accepted;
    logic slot_free;
    logic burst_open;
    logic empty_header;
    logic last_consumed;
    logic finish;

    assign accepted  = mem_req.read && !mem_rsp.waitrequest;

    // slots not yet promised to a burst that is still in flight
    assign slot_free = free_slots > reserved;

    assign burst_open = (issue_state == raster_pkg::ISSUE_BURST) && !mem_req.read &&
                        (issued_cnt != tri_count) && slot_free;

    assign empty_header  = busy && (recv_state == raster_pkg::RECV_HEADER) &&
                           mem_rsp.readdatavalid && (mem_rsp.readdata == 32'd0);
    assign last_consumed = consumed && (consumed_cnt + 32'd1 == tri_count);
    assign finish        = empty_header || last_consumed;

    // request side, the address simply walks up one word per accepted read
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            issue_state <= raster_pkg::ISSUE_IDLE;
            mem_req     <= '0;
            send_idx    <= '0;
            issued_cnt  <= '0;
        end else if (finish) begin
            issue_state  <= raster_pkg::ISSUE_IDLE;
            mem_req.read <= 1'b0;
        end else begin
            case (issue_state)
                raster_pkg::ISSUE_IDLE: begin
                    if (start) begin
                        mem_req.read    <= 1'b1;
                        mem_req.address <= base_addr;
                        send_idx        <= '0;
                        issued_cnt      <= '0;
                        issue_state     <= raster_pkg::ISSUE_HEADER;
                    end
                end
                raster_pkg::ISSUE_HEADER: begin
                    if (accepted) begin
                        mem_req.read    <= 1'b0;
                        mem_req.address <= mem_req.address + `RASTER_ADDR_W'(4);
                    end else if (!mem_req.read && recv_state == raster_pkg::RECV_TRIANGLE) begin
                        issue_state <= raster_pkg::ISSUE_BURST;
                    end
                end
                raster_pkg::ISSUE_BURST: begin
                    if (accepted) begin
                        mem_req.address <= mem_req.address + `RASTER_ADDR_W'(4);
                        if (send_idx == LAST_IDX) begin
                            mem_req.read <= 1'b0;
                            send_idx     <= '0;
                            issued_cnt   <= issued_cnt + 32'd1;
                        end else begin
                            send_idx <= send_idx + 1'b1;
                        end
                    end else if (!mem_req.read && issued_cnt == tri_count) begin
                        issue_state <= raster_pkg::ISSUE_DONE;
                    end else if (burst_open) begin
                        mem_req.read <= 1'b1;
                    end
                end
                // all bursts are out, wait for the rasterizer to drain them
                raster_pkg::ISSUE_DONE: begin
                    mem_req.read <= 1'b0;
                end
                default: begin
                    issue_state <= raster_pkg::ISSUE_IDLE;
                end
            endcase
        end
    end

    // a slot is held from a burst's first request until its triangle is pushed
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            reserved <= '0;
        end else begin
            case ({burst_open, push})
                2'b10:   reserved <= reserved + 1'b1;
                2'b01:   reserved <= reserved - 1'b1;
                default: reserved <= reserved;
            endcase
        end
    end

    // response side, data comes back in request order
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            recv_state <= raster_pkg::RECV_HEADER;
            recv_idx   <= '0;
            tri_count  <= '0;
            push       <= 1'b0;
        end else begin
            push <= 1'b0;
            if (start) begin
                recv_state <= raster_pkg::RECV_HEADER;
                recv_idx   <= '0;
            end else if (mem_rsp.readdatavalid) begin
                case (recv_state)
                    raster_pkg::RECV_HEADER: begin
                        tri_count  <= mem_rsp.readdata;
                        recv_state <= raster_pkg::RECV_TRIANGLE;
                    end
                    raster_pkg::RECV_TRIANGLE: begin
                        if (recv_idx == LAST_IDX) begin
                            recv_idx <= '0;
                            push     <= 1'b1;
                        end else begin
                            recv_idx <= recv_idx + 1'b1;
                        end
                    end
                    default: begin
                        recv_state <= raster_pkg::RECV_HEADER;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (mem_rsp.readdatavalid && recv_state == raster_pkg::RECV_TRIANGLE) begin
            push_tri.word[recv_idx] <= mem_rsp.readdata;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            consumed_cnt <= '0;
            busy         <= 1'b0;
            done         <= 1'b0;
        end else if (start) begin
            consumed_cnt <= '0;
            busy         <= 1'b1;
            done         <= 1'b0;
        end else begin
            if (consumed) begin
                consumed_cnt <= consumed_cnt + 32'd1;
            end
            if (finish) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the raster front end testbench with Verilator and runs it into sim.log
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 -f sources.f --top-module tb_raster_frontend
status=0
./obj_dir/Vtb_raster_frontend > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "TB FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"

/* sources.f */
+incdir+hw
hw/raster_pkg.sv
hw/raster_apb_regs.sv
hw/triangle_fifo.sv
hw/vertex_fetch.sv
hw/raster_frontend_top.sv
verif/tb_mem_model.sv
verif/tb_raster_frontend.sv

/* verif/tb_mem_model.sv */
`include "raster_defs.svh"

module tb_mem_model (
    input  logic                      clock,
    input  logic                      reset,
    input  raster_pkg::mem_req_t      mem_req,
    output raster_pkg::mem_rsp_t      mem_rsp,
    input  logic [`RASTER_ADDR_W-1:0] header_addr,
    input  logic [31:0]               header_count
);

    logic [`RASTER_ADDR_W-1:0] addr_q [$];
    int                        due_q [$];
    logic [`RASTER_ADDR_W-1:0] req_addr;
    logic [`RASTER_ADDR_W-1:0] rsp_addr;
    logic                      req_taken;
    int                        cycle;
    integer                    seed;

    // every word of the buffer depends on its full byte address
    function automatic logic [31:0] fill_word(input logic [`RASTER_ADDR_W-1:0] addr);
        return {addr[7:2], addr} ^ 32'h3c96_a5f0;
    endfunction

    initial begin
        seed    = 32'h869e_586d;
        cycle   = 0;
        mem_rsp = '0;
    end

    // the request seen here is the one the DUT presents at the next rising edge
    always @(negedge clock) begin
        req_taken = mem_req.read && !mem_rsp.waitrequest;
        req_addr  = mem_req.address;
    end

    always @(posedge clock) begin
        cycle = cycle + 1;
        if (!reset) begin
            addr_q.delete();
            due_q.delete();
            #1;
            mem_rsp = '0;
        end else begin
            if (req_taken) begin
                addr_q.push_back(req_addr);
                due_q.push_back(cycle + ($random(seed) & 3));
            end
            #1;
            mem_rsp.waitrequest = (($random(seed) & 3) == 0);
            // only the oldest request may return, which keeps data in order
            if (due_q.size() > 0 && due_q[0] <= cycle) begin
                rsp_addr = addr_q.pop_front();
                void'(due_q.pop_front());
                mem_rsp.readdatavalid = 1'b1;
                mem_rsp.readdata = (rsp_addr == header_addr) ? header_count : fill_word(rsp_addr);
            end else begin
                mem_rsp.readdatavalid = 1'b0;
                mem_rsp.readdata      = 32'd0;
            end
        end
    end

endmodule

/* verif/tb_raster_frontend.sv */
`include "raster_defs.svh"

module tb_raster_frontend;

    localparam int TOTAL_TRIS = 15;

    logic                      clock;
    logic                      reset;
    logic                      stall;
    logic                      stall_random;
    raster_pkg::apb_req_t      apb_req;
    raster_pkg::apb_rsp_t      apb_rsp;
    raster_pkg::mem_req_t      mem_req;
    raster_pkg::mem_rsp_t      mem_rsp;
    raster_pkg::triangle_t     tri_out;
    logic                      tri_valid;
    logic [`RASTER_ADDR_W-1:0] hdr_addr;
    logic [31:0]               hdr_count;
    logic [`RASTER_ADDR_W-1:0] exp_base;
    logic [31:0]               rdata;
    int                        exp_count;
    int                        exp_k;
    integer                    seed;
    string                     test_name;

    raster_frontend_top UUT (
        .clock     (clock),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .tri_out   (tri_out),
        .tri_valid (tri_valid),
        .stall     (stall)
    );

    tb_mem_model u_mem (
        .clock        (clock),
        .reset        (reset),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .header_addr  (hdr_addr),
        .header_count (hdr_count)
    );

    always #5 clock = ~clock;

    // word j of triangle k sits at BASE + 4 + 60k + 4j
    function automatic logic [31:0] expected_word(input logic [`RASTER_ADDR_W-1:0] base,
                                                  input int k, input int j);
        logic [`RASTER_ADDR_W-1:0] addr;
        addr = base + `RASTER_ADDR_W'(4 + 60 * k + 4 * j);
        return {addr[7:2], addr} ^ 32'h3c96_a5f0;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("** Error %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // prdata is taken in the middle of the access cycle that follows the setup cycle
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] data);
        @(posedge clock);
        #1;
        apb_req = {1'b1, 1'b0, write, addr, wdata};
        @(posedge clock);
        #1;
        apb_req.penable = 1'b1;
        #3;
        if (!apb_rsp.pready) begin
            report_failure("APB access phase did not see pready");
        end
        data = apb_rsp.prdata;
        @(posedge clock);
        #1;
        apb_req = '0;
    endtask

    task automatic run_frontend(input string name, input logic [`RASTER_ADDR_W-1:0] base,
                                input int count, input logic use_stall, input logic poke_busy);
        logic [31:0] status;
        test_name    = name;
        exp_base     = base;
        exp_count    = count;
        exp_k        = 0;
        hdr_addr     = base;
        hdr_count    = 32'(count);
        stall_random = use_stall;
        apb_transfer(1'b1, `RASTER_REG_BASE, {{(32 - `RASTER_ADDR_W){1'b0}}, base}, status);
        apb_transfer(1'b1, `RASTER_REG_CTRL, 32'd1, status);
        if (poke_busy) begin
            apb_transfer(1'b0, `RASTER_REG_STATUS, 32'd0, status);
            check_value(name, 32'h1, status);
            apb_transfer(1'b1, `RASTER_REG_CTRL, 32'd1, status);
        end
        status = 32'd0;
        while (!status[1]) begin
            apb_transfer(1'b0, `RASTER_REG_STATUS, 32'd0, status);
        end
        stall_random = 1'b0;
        check_value(name, 32'h2, status);
        apb_transfer(1'b0, `RASTER_REG_COUNT, 32'd0, status);
        check_value(name, 32'(count), status);
        check_value(name, 32'(count), 32'(exp_k));
    endtask

    // a triangle is consumed at the next rising edge when valid and not stalled
    always @(negedge clock) begin
        if (reset && tri_valid && !stall) begin
            if (exp_k >= exp_count) begin
                report_failure("a triangle was delivered beyond the header count");
            end
            for (int j = 0; j < `RASTER_TRI_WORDS; j++) begin
                check_value(test_name, expected_word(exp_base, exp_k, j), tri_out.word[j]);
            end
            exp_k = exp_k + 1;
        end
    end

    always @(posedge clock) begin
        #1;
        stall = stall_random ? (($random(seed) & 3) != 0) : 1'b0;
    end

    initial begin
        repeat (TOTAL_TRIS * 400 + 2000) @(posedge clock);
        report_failure("watchdog timeout, the tests did not finish in time");
    end

    initial begin
        clock        = 1'b0;
        reset        = 1'b0;
        stall        = 1'b0;
        stall_random = 1'b0;
        apb_req      = '0;
        hdr_addr     = '0;
        hdr_count    = 32'd0;
        exp_base     = '0;
        exp_count    = 0;
        exp_k        = 0;
        seed         = 32'h869e_586d;
        test_name    = "reset_and_base";
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b1;
        check_value(test_name, 32'd0, {30'd0, tri_valid, mem_req.read});
        apb_transfer(1'b0, `RASTER_REG_STATUS, 32'd0, rdata);
        check_value(test_name, 32'd0, rdata);
        apb_transfer(1'b1, `RASTER_REG_BASE, 32'h0012_3450, rdata);
        apb_transfer(1'b0, `RASTER_REG_BASE, 32'd0, rdata);
        check_value(test_name, 32'h0012_3450, rdata);
        run_frontend("three_triangles", 26'h001_0000, 3, 1'b0, 1'b0);
        run_frontend("ten_with_stall", 26'h020_0400, 10, 1'b1, 1'b0);
        run_frontend("zero_header", 26'h030_0000, 0, 1'b0, 1'b0);
        run_frontend("ctrl_while_busy", 26'h004_1000, 2, 1'b0, 1'b1);
        $display("TB PASSED");
        $finish;
    end

endmodule
